/* design/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address and data word
`define ICACHE_ADDR_W   32
`define ICACHE_XLEN     64

// address split: tag | index | offset
`define ICACHE_OFFSET_W 5
`define ICACHE_INDEX_W  6
`define ICACHE_TAG_W    21

// 64-bit beats per 32-byte line
`define ICACHE_BEATS    4

// way count, power of two (2 or 4)
`define ICACHE_WAYS     2

`endif

/* design/icachePkg.sv */
`default_nettype none

`include "icache_macros.svh"

package icachePkg;

  // address fields, msb first
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [`ICACHE_INDEX_W-1:0] index;
    // word inside the line
    logic [1:0]                 wordSel;
    // byte inside the word, ignored
    logic [2:0]                 byteOff;
  } fetchFields_t;

  // one fetch address, seen raw or split into fields
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    fetchFields_t              fields;
  } fetchAddr_u;

  // full line, beat 0 in the low word
  typedef logic [`ICACHE_BEATS-1:0][`ICACHE_XLEN-1:0] cacheLine_t;

  // way number, wide enough for any way
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] wayNum_t;

  // lookup / refill FSM
  typedef enum logic [2:0] {
    idle    = 3'd0,
    compare = 3'd1,
    miss    = 3'd2,
    getData = 3'd3,
    fill    = 3'd4
  } ctrlState_e;

endpackage

`default_nettype wire

/* design/cacheWayIf.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

// controller to ways, one instance shared by all ways
interface wayCtrlIf import icachePkg::*; ();
  // array read strobe and set
  logic                         lookupEn;
  logic [`ICACHE_INDEX_W-1:0]   lookupIndex;
  // tag of the request in compare
  logic [`ICACHE_TAG_W-1:0]     cmpTag;
  // one-cycle line write
  logic                         fillEn;
  wayNum_t                      fillWay;
  logic [`ICACHE_INDEX_W-1:0]   fillIndex;
  logic [`ICACHE_TAG_W-1:0]     fillTag;
  cacheLine_t                   fillLine;

  modport ctrl (
    output lookupEn, lookupIndex, cmpTag,
    output fillEn, fillWay, fillIndex, fillTag, fillLine
  );
  modport way (
    input lookupEn, lookupIndex, cmpTag,
    input fillEn, fillWay, fillIndex, fillTag, fillLine
  );
endinterface

// one way back to the hit selector
interface wayRespIf import icachePkg::*; ();
  logic       hit;
  // valid bit of the looked-up set
  logic       lineValid;
  cacheLine_t line;

  modport way (output hit, lineValid, line);
  modport sel (input hit, lineValid, line);
endinterface

`default_nettype wire

/* design/cacheWay.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module cacheWay import icachePkg::*; #(
  // position in the generate loop
  parameter int unsigned wayId = 0
) (
  input logic   clk,
  input logic   rst_n,
  wayCtrlIf.way ctrl_i,
  wayRespIf.way resp_o
);

  localparam int SETS = 1 << `ICACHE_INDEX_W;
  localparam wayNum_t MY_WAY = wayNum_t'(wayId);

  // storage, behavioural stand-ins for the SRAMs
  logic [`ICACHE_TAG_W-1:0] tagArr [SETS];
  cacheLine_t               dataArr [SETS];
  logic [SETS-1:0]          validVec;

  // registered read port
  logic [`ICACHE_TAG_W-1:0] tagQ;
  cacheLine_t               lineQ;
  logic                     validQ;

  logic                     fillMine;

  // fill aimed at this way only
  assign fillMine = ctrl_i.fillEn && (ctrl_i.fillWay == MY_WAY);

  // valid bits, all clear out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validVec <= '0;
    end else if (fillMine) begin
      validVec[ctrl_i.fillIndex] <= 1'b1;
    end
  end

  // tag and line write
  always_ff @(posedge clk) begin
    if (fillMine) begin
      tagArr[ctrl_i.fillIndex]  <= ctrl_i.fillTag;
      dataArr[ctrl_i.fillIndex] <= ctrl_i.fillLine;
    end
  end

  // read data appears the cycle after the strobe
  always_ff @(posedge clk) begin
    if (ctrl_i.lookupEn) begin
      tagQ  <= tagArr[ctrl_i.lookupIndex];
      lineQ <= dataArr[ctrl_i.lookupIndex];
    end
  end

  // valid read kept with the other control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (ctrl_i.lookupEn) begin
      validQ <= validVec[ctrl_i.lookupIndex];
    end
  end

  // compare against the request now in compare
  assign resp_o.hit       = validQ && (tagQ == ctrl_i.cmpTag);
  assign resp_o.lineValid = validQ;
  assign resp_o.line      = lineQ;

  // single-port array, no read in a write cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    fillMine |-> !ctrl_i.lookupEn)
    else $error("way %0d: lookup during fill", wayId);

endmodule

`default_nettype wire

/* design/refillCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module refillCtrl import icachePkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  // fetch side
  input  logic                       valid_i,
  input  logic                       stall_n_i,
  input  fetchAddr_u                 addr_i,
  output logic                       addrOk_o,
  // memory read port
  output logic                       cacheRdValid_o,
  output logic [`ICACHE_ADDR_W-1:0]  cacheAddr_o,
  input  logic                       axiRdReady_i,
  input  logic [`ICACHE_XLEN-1:0]    rdData_i,
  input  logic                       dataValid_i,
  input  logic                       rdLast_i,
  // from the hit selector
  input  logic                       anyHit_i,
  input  logic [`ICACHE_WAYS-1:0]    lineValid_i,
  output fetchAddr_u                 reqAddr_o,
  output logic                       inCompare_o,
  wayCtrlIf.ctrl                     ctrl_o
);

  ctrlState_e curState;
  ctrlState_e nextState;
  fetchAddr_u reqLatch;
  logic       accept;
  logic       fillPhase;
  logic       reLookup;
  logic [1:0] beatCnt;
  cacheLine_t rdBuffer;
  logic [15:0] lfsr;
  wayNum_t    victim;

  // new request only when idle or on a hit and never while stalled
  assign addrOk_o = stall_n_i &&
                    ((curState == idle) || ((curState == compare) && anyHit_i));
  assign accept   = valid_i && addrOk_o;

  // fill takes two cycles to write and then re-read the set
  assign reLookup = (curState == fill) && fillPhase;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= idle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      idle: begin
        if (accept) nextState = compare;
      end
      compare: begin
        // a stalled hit holds its word in compare
        if (!anyHit_i) nextState = miss;
        else if (accept) nextState = compare;
        else if (stall_n_i) nextState = idle;
      end
      miss: begin
        if (axiRdReady_i) nextState = getData;
      end
      getData: begin
        if (dataValid_i && rdLast_i) nextState = fill;
      end
      fill: begin
        // replay the lookup that now hits
        if (fillPhase) nextState = compare;
      end
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fillPhase <= 1'b0;
    end else begin
      fillPhase <= (curState == fill) && !fillPhase;
    end
  end

  // request latch loaded on acceptance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqLatch <= '0;
    end else if (accept) begin
      reqLatch <= addr_i;
    end
  end

  // beat counter restarting for every miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (curState == miss) begin
      beatCnt <= '0;
    end else if ((curState == getData) && dataValid_i) begin
      beatCnt <= beatCnt + 2'd1;
    end
  end

  // refill buffer takes every beat so memory sees no back-pressure
  always_ff @(posedge clk) begin
    if ((curState == getData) && dataValid_i) begin
      rdBuffer[beatCnt] <= rdData_i;
    end
  end

  // x^16 + x^14 + x^13 + x^11 stepping once per fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= 16'hACE1;
    end else if (ctrl_o.fillEn) begin
      lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end
  end

  // lowest invalid way wins and the LFSR picks otherwise
  always_comb begin
    victim = wayNum_t'(lfsr);
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!lineValid_i[w]) victim = wayNum_t'(w);
    end
  end

  // line base of the latched request
  assign cacheRdValid_o = (curState == miss);
  assign cacheAddr_o    = {reqLatch.fields.tag, reqLatch.fields.index,
                           {`ICACHE_OFFSET_W{1'b0}}};

  assign reqAddr_o   = reqLatch;
  assign inCompare_o = (curState == compare);

  // lookup index from the port on accept and from the latch on replay
  assign ctrl_o.lookupEn    = accept || reLookup;
  assign ctrl_o.lookupIndex = accept ? addr_i.fields.index : reqLatch.fields.index;
  assign ctrl_o.cmpTag      = reqLatch.fields.tag;
  assign ctrl_o.fillEn      = (curState == fill) && !fillPhase;
  assign ctrl_o.fillWay     = victim;
  assign ctrl_o.fillIndex   = reqLatch.fields.index;
  assign ctrl_o.fillTag     = reqLatch.fields.tag;
  assign ctrl_o.fillLine    = rdBuffer;

  // memory grants only a pending read request
  assert property (@(posedge clk) disable iff (!rst_n)
    axiRdReady_i |-> cacheRdValid_o)
    else $error("axiRdReady_i without a read request");

  // memory beats only while the line is being read
  assert property (@(posedge clk) disable iff (!rst_n)
    dataValid_i |-> (curState == getData))
    else $error("dataValid_i outside getData");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl_o.fillEn && ctrl_o.lookupEn))
    else $error("fill and lookup in one cycle");

endmodule

`default_nettype wire

/* design/hitSelect.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module hitSelect import icachePkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  wayRespIf.sel                    resp_i [`ICACHE_WAYS],
  input  fetchAddr_u               reqAddr_i,
  input  logic                     inCompare_i,
  output logic                     anyHit_o,
  output logic [`ICACHE_WAYS-1:0]  lineValid_o,
  output logic [`ICACHE_XLEN-1:0]  rdData_o,
  output logic                     dataOk_o
);

  logic [`ICACHE_WAYS-1:0] hitVec;
  cacheLine_t              lineArr [`ICACHE_WAYS];

  // flatten the interface array
  for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : gCollect
    assign hitVec[g]      = resp_i[g].hit;
    assign lineValid_o[g] = resp_i[g].lineValid;
    assign lineArr[g]     = resp_i[g].line;
  end

  assign anyHit_o = |hitVec;

  // one-hot and-or mux, word picked by wordSel
  always_comb begin
    rdData_o = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      rdData_o = rdData_o |
                 ({`ICACHE_XLEN{hitVec[w]}} & lineArr[w][reqAddr_i.fields.wordSel]);
    end
  end

  // word valid only for the request in compare
  assign dataOk_o = inCompare_i && anyHit_o;

  // a tag lives in one way of a set at most
  assert property (@(posedge clk) disable iff (!rst_n)
    inCompare_i |-> $onehot0(hitVec))
    else $error("multiple ways hit, hitVec=%b", hitVec);

endmodule

`default_nettype wire

/* design/icacheTop.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icacheTop import icachePkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  // fetch side
  input  logic                       valid_i,
  input  logic [`ICACHE_ADDR_W-1:0]  addr_i,
  input  logic                       stall_n_i,
  output logic                       addrOk_o,
  output logic                       dataOk_o,
  output logic [`ICACHE_XLEN-1:0]    rdData_o,
  // memory read port
  output logic                       cacheRdValid_o,
  input  logic                       axiRdReady_i,
  output logic [`ICACHE_ADDR_W-1:0]  cacheAddr_o,
  input  logic [`ICACHE_XLEN-1:0]    rdData_i,
  input  logic                       dataValid_i,
  input  logic                       rdLast_i
);

  fetchAddr_u              fetchAddr;
  fetchAddr_u              reqAddr;
  logic                    anyHit;
  logic                    inCompare;
  logic [`ICACHE_WAYS-1:0] lineValid;

  // controller feeds every way, selector drains them
  wayCtrlIf ctrlBus ();
  wayRespIf respBus [`ICACHE_WAYS] ();

  assign fetchAddr.raw = addr_i;

  refillCtrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .stall_n_i      (stall_n_i),
    .addr_i         (fetchAddr),
    .addrOk_o       (addrOk_o),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .axiRdReady_i   (axiRdReady_i),
    .rdData_i       (rdData_i),
    .dataValid_i    (dataValid_i),
    .rdLast_i       (rdLast_i),
    .anyHit_i       (anyHit),
    .lineValid_i    (lineValid),
    .reqAddr_o      (reqAddr),
    .inCompare_o    (inCompare),
    .ctrl_o         (ctrlBus)
  );

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gWay
    cacheWay #(.wayId(w)) u_way (
      .clk    (clk),
      .rst_n  (rst_n),
      .ctrl_i (ctrlBus),
      .resp_o (respBus[w])
    );
  end

  hitSelect u_sel (
    .clk         (clk),
    .rst_n       (rst_n),
    .resp_i      (respBus),
    .reqAddr_i   (reqAddr),
    .inCompare_i (inCompare),
    .anyHit_o    (anyHit),
    .lineValid_o (lineValid),
    .rdData_o    (rdData_o),
    .dataOk_o    (dataOk_o)
  );

endmodule

`default_nettype wire

/* test/tbMemPattern.svh */
// memory word as a function of the full byte address
// upper and lower halves scrambled differently
function automatic logic [63:0] memWord(input logic [31:0] addr);
  logic [31:0] hi;
  logic [31:0] lo;
  hi = addr ^ 32'h5A5A_A5A5;
  // multiply spreads low address bits into the high ones
  lo = (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  return {hi, lo};
endfunction

/* test/tbMemModel.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

// read responder, ready after 0..3 cycles, then four beats with gaps
module tbMemModel (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cacheRdValid_i,
  input  logic [`ICACHE_ADDR_W-1:0] cacheAddr_i,
  output logic                      axiRdReady_o,
  output logic [`ICACHE_XLEN-1:0]   rdData_o,
  output logic                      dataValid_o,
  output logic                      rdLast_o
);

  `include "tbMemPattern.svh"

  // one ready cycle, then the line beat by beat
  task automatic serveLine();
    logic [`ICACHE_ADDR_W-1:0] base;
    int unsigned gap;
    base = cacheAddr_i;
    repeat ($urandom % 4) begin
      @(posedge clk);
      #1;
    end
    axiRdReady_o = 1'b1;
    @(posedge clk);
    #1;
    axiRdReady_o = 1'b0;
    for (int b = 0; b < `ICACHE_BEATS; b++) begin
      gap = $urandom % 3;
      // idle cycles between beats
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      dataValid_o = 1'b1;
      rdData_o    = memWord(base + 32'(b * 8));
      rdLast_o    = (b == `ICACHE_BEATS - 1);
      @(posedge clk);
      #1;
      dataValid_o = 1'b0;
      rdLast_o    = 1'b0;
    end
  endtask

  initial begin
    axiRdReady_o = 1'b0;
    dataValid_o  = 1'b0;
    rdLast_o     = 1'b0;
    rdData_o     = '0;
    // look for a read request just after every edge
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && cacheRdValid_i) serveLine();
    end
  end

endmodule

`default_nettype wire

/* test/icacheTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icacheTb import icachePkg::*; ();

  localparam int PERIOD     = 4;
  localparam int RST_CYCLES = 3;
  localparam int WAYS       = `ICACHE_WAYS;
  localparam int SETS       = 1 << `ICACHE_INDEX_W;
  localparam int RAND_REQ   = 80;
  // fetches issued by all tests together
  localparam int TOTAL_REQ  = 1 + 4 + 4 + 1 + RAND_REQ + 3;
  localparam int LIMIT      = RST_CYCLES + TOTAL_REQ * 40;

  `include "tbMemPattern.svh"

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      valid_i;
  logic [`ICACHE_ADDR_W-1:0] addr_i;
  logic                      stall_n_i;
  logic                      addrOk_o;
  logic                      dataOk_o;
  logic [`ICACHE_XLEN-1:0]   rdData_o;
  logic                      cacheRdValid_o;
  logic                      axiRdReady_i;
  logic [`ICACHE_ADDR_W-1:0] cacheAddr_o;
  logic [`ICACHE_XLEN-1:0]   rdData_i;
  logic                      dataValid_i;
  logic                      rdLast_i;

  // accepted fetches waiting for dataOk_o
  fetchAddr_u pending [$];
  fetchAddr_u req;
  fetchAddr_u accAddr;
  int         doneCycle [$];
  logic       missSeen;
  int         cycleCnt = 0;
  int         holdCount = 0;
  int         errCount = 0;
  int         seqErrs = 0;
  int         testErrBase = 0;
  int         testsRun = 0;
  int         testsFailed = 0;
  string      curTest;

  // tags certain to be resident plus ways of unknown content
  logic [`ICACHE_TAG_W-1:0] knownTag [SETS][WAYS];
  int                       knownCnt [SETS];
  int                       unknownCnt [SETS];

  always #(PERIOD / 2) clk = ~clk;

  icacheTop u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .stall_n_i      (stall_n_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .cacheRdValid_o (cacheRdValid_o),
    .axiRdReady_i   (axiRdReady_i),
    .cacheAddr_o    (cacheAddr_o),
    .rdData_i       (rdData_i),
    .dataValid_i    (dataValid_i),
    .rdLast_i       (rdLast_i)
  );

  tbMemModel u_mem (
    .clk            (clk),
    .rst_n          (rst_n),
    .cacheRdValid_i (cacheRdValid_o),
    .cacheAddr_i    (cacheAddr_o),
    .axiRdReady_o   (axiRdReady_i),
    .rdData_o       (rdData_i),
    .dataValid_o    (dataValid_i),
    .rdLast_o       (rdLast_i)
  );

  function automatic logic [31:0] mkAddr(input int tag, input int idx, input int word,
                                         input int off);
    fetchAddr_u a;
    a.fields.tag     = `ICACHE_TAG_W'(tag);
    a.fields.index   = `ICACHE_INDEX_W'(idx);
    a.fields.wordSel = 2'(word);
    a.fields.byteOff = 3'(off);
    return a.raw;
  endfunction

  // byte offset bits cleared
  function automatic logic [31:0] lineBase(input fetchAddr_u a);
    return a.raw & ~((32'd1 << `ICACHE_OFFSET_W) - 32'd1);
  endfunction

  // expected word at the line base plus eight bytes per word
  function automatic logic [63:0] expectWord(input fetchAddr_u a);
    return memWord(lineBase(a) + 32'(a.fields.wordSel) * 32'd8);
  endfunction

  function automatic bit tagKnown(input fetchAddr_u a);
    bit found;
    found = 1'b0;
    for (int w = 0; w < knownCnt[a.fields.index]; w++) begin
      if (knownTag[a.fields.index][w] == a.fields.tag) found = 1'b1;
    end
    return found;
  endfunction

  task automatic checkWord(input string name, input fetchAddr_u addr, input logic [63:0] act);
    if (act !== expectWord(addr)) begin
      $display("Error %s: word at %h expected %h actual %h", name, addr.raw,
               expectWord(addr), act);
      errCount++;
    end
  endtask

  task automatic checkMiss(input string name, input fetchAddr_u addr, input logic exp,
                           input logic act);
    if (act !== exp) begin
      $display("Error %s: miss for %h expected %0b actual %0b", name, addr.raw, exp, act);
      errCount++;
    end
  endtask

  task automatic checkAddr(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error %s: cacheAddr_o expected %h actual %h", name, exp, act);
      errCount++;
    end
  endtask

  task automatic checkBit(input string name, input string what, input logic exp,
                          input logic act);
    if (act !== exp) begin
      $display("Error %s: %s expected %0b actual %0b", name, what, exp, act);
      errCount++;
    end
  endtask

  task automatic checkCount(input string name, input string what, input int exp, input int act);
    if (act != exp) begin
      $display("Error %s: %s expected %0d actual %0d", name, what, exp, act);
      seqErrs++;
    end
  endtask

  // miss check only where the residency model is certain and then a model update
  task automatic noteOutcome(input fetchAddr_u a, input logic missed);
    int  idx;
    bit  known;
    idx   = int'(a.fields.index);
    known = tagKnown(a);
    if (known || unknownCnt[idx] == 0) checkMiss(curTest, a, !known, missed);
    if (!known && !missed && unknownCnt[idx] > 0) begin
      // hit in a way we had lost track of
      knownTag[idx][knownCnt[idx]] = a.fields.tag;
      knownCnt[idx]++;
      unknownCnt[idx]--;
    end else if (!known && missed && knownCnt[idx] + unknownCnt[idx] < WAYS) begin
      knownTag[idx][knownCnt[idx]] = a.fields.tag;
      knownCnt[idx]++;
    end else if (!known && missed) begin
      // eviction with an unknown victim
      knownTag[idx][0] = a.fields.tag;
      knownCnt[idx]    = 1;
      unknownCnt[idx]  = WAYS - 1;
    end
  endtask

  // compare process sampling mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        knownCnt[s]   = 0;
        unknownCnt[s] = 0;
      end
      missSeen = 1'b0;
    end else begin
      cycleCnt++;
      if (cycleCnt == 1) begin
        checkBit(curTest, "addrOk_o after reset", 1'b1, addrOk_o);
        checkBit(curTest, "dataOk_o after reset", 1'b0, dataOk_o);
        checkBit(curTest, "cacheRdValid_o after reset", 1'b0, cacheRdValid_o);
      end
      if (!stall_n_i) begin
        checkBit(curTest, "addrOk_o while stalled", 1'b0, addrOk_o);
        if (dataOk_o) holdCount++;
      end
      if (dataOk_o && pending.size() == 0) begin
        $display("%s: dataOk_o high with no fetch outstanding", curTest);
        errCount++;
      end else if (dataOk_o) begin
        // held word is checked on every stalled cycle too
        checkWord(curTest, pending[0], rdData_o);
        if (stall_n_i) begin
          req = pending.pop_front();
          noteOutcome(req, missSeen);
          doneCycle.push_back(cycleCnt);
          missSeen = 1'b0;
        end
      end
      if (cacheRdValid_o && !missSeen && pending.size() != 0) begin
        missSeen = 1'b1;
        checkAddr(curTest, lineBase(pending[0]), cacheAddr_o);
      end
      if (valid_i && addrOk_o) begin
        accAddr.raw = addr_i;
        pending.push_back(accAddr);
      end
    end
  end

  // present a fetch until the DUT takes it
  task automatic issue(input logic [31:0] a);
    logic ok;
    valid_i = 1'b1;
    addr_i  = a;
    ok      = 1'b0;
    while (!ok) begin
      @(negedge clk);
      ok = addrOk_o;
      @(posedge clk);
      #1;
    end
    valid_i = 1'b0;
  endtask

  task automatic waitDrained();
    while (pending.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic beginTest(input string name);
    curTest     = name;
    testErrBase = errCount + seqErrs;
  endtask

  task automatic endTest();
    int errs;
    errs = errCount + seqErrs - testErrBase;
    testsRun++;
    if (errs != 0) testsFailed++;
    $display("test %s finished with %0d error(s)", curTest, errs);
  endtask

  initial begin
    int startIdx;
    int holdBase;
    void'($urandom(64473));
    rst_n     = 1'b0;
    valid_i   = 1'b0;
    addr_i    = '0;
    stall_n_i = 1'b1;
    beginTest("coldMiss");
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    issue(mkAddr(1, 1, 3, 0));
    waitDrained();
    endTest();

    // whole line back to back at one word per cycle
    beginTest("lineHits");
    startIdx = doneCycle.size();
    for (int w = 0; w < 4; w++) issue(mkAddr(1, 1, w, 4));
    waitDrained();
    for (int i = 1; i < 4; i++) begin
      checkCount(curTest, "dataOk_o cycle", doneCycle[startIdx] + i, doneCycle[startIdx + i]);
    end
    endTest();

    // two tags into set 5 with the invalid way taken first
    beginTest("bothWays");
    issue(mkAddr(2, 5, 0, 0));
    issue(mkAddr(3, 5, 1, 0));
    issue(mkAddr(2, 5, 2, 0));
    issue(mkAddr(3, 5, 3, 0));
    waitDrained();
    endTest();

    // third tag evicts and random traffic follows over 8 sets
    beginTest("eviction");
    issue(mkAddr(4, 5, 0, 0));
    for (int i = 0; i < RAND_REQ; i++) begin
      issue(mkAddr(1 + $urandom % 4, $urandom % 8, $urandom % 4, $urandom % 8));
      if ($urandom % 3 == 0) begin
        @(posedge clk);
        #1;
      end
    end
    waitDrained();
    endTest();

    // hit held in compare while stall_n_i is low
    beginTest("stall");
    issue(mkAddr(5, 9, 2, 0));
    waitDrained();
    issue(mkAddr(5, 9, 2, 0));
    stall_n_i = 1'b0;
    valid_i   = 1'b1;
    addr_i    = mkAddr(5, 9, 1, 0);
    holdBase  = holdCount;
    repeat (3) @(negedge clk);
    @(posedge clk);
    #1;
    checkCount(curTest, "held dataOk_o cycles", 3, holdCount - holdBase);
    stall_n_i = 1'b1;
    issue(mkAddr(5, 9, 1, 0));
    waitDrained();
    endTest();

    $display("summary: %0d tests, %0d failed, %0d check errors", testsRun, testsFailed,
             errCount + seqErrs);
    if (errCount + seqErrs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog allowing 40 cycles per fetch plus reset
  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("watchdog: no finish after %0d cycles, the DUT stopped responding", LIMIT);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
+incdir+test
design/icachePkg.sv
design/cacheWayIf.sv
design/cacheWay.sv
design/refillCtrl.sv
design/hitSelect.sv
design/icacheTop.sv
test/tbMemModel.sv
test/icacheTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= icacheTb
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard design/*.svh test/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

check: run
	@grep -qx "TEST OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
